/* flist.f */
+incdir+include
rtl/mem_bridge_pkg.sv
rtl/wb_cycle_decode.sv
rtl/sdram_burst_exec.sv
rtl/readahead_buffer.sv
rtl/mem_bridge_top.sv
sim/tb_mem_bridge.sv

/* Bender.yml */
package:
  name: mem_bridge

sources:
  - files:
      - rtl/mem_bridge_pkg.sv
      - rtl/wb_cycle_decode.sv
      - rtl/sdram_burst_exec.sv
      - rtl/readahead_buffer.sv
      - rtl/mem_bridge_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_mem_bridge.sv

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// compare tasks
////////////////////

// read word against the shadow memory
task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input logic [ADDR_W-1:0] adr);
   if (got !== exp) begin
      $display("Mismatch at %0t ns: read at 0x%03h gave 0x%08h, expected 0x%08h",
               $time, adr, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "read data differs from the shadow memory");
   end
endtask

// no ack may show up outside a bus cycle
task automatic check_ack_idle(input logic ack);
   if (ack !== 1'b0) begin
      $display("Mismatch at %0t ns: wb_ack_o is %b with no bus cycle", $time, ack);
      $display("TEST RESULT: FAIL");
      $fatal(1, "acknowledge outside a bus cycle");
   end
endtask

////////////////////
// wishbone master
////////////////////

// returns 2 ns after the edge that raised ack
task automatic wait_ack();
   do begin
      @(posedge wb_clk);
      #2;
   end while (wb_ack_o !== 1'b1);   // watchdog bounds this loop
endtask

task automatic start_cycle();
   @(posedge wb_clk);
   #2;
   wb_cyc_i = 1'b1;
endtask

task automatic end_cycle();
   wb_cyc_i = 1'b0;
   wb_stb_i = 1'b0;
   wb_we_i  = 1'b0;
endtask

// one write inside an open cycle, shadow follows on ack
task automatic put_word(input logic [WORD_AW-1:0] a, input logic [DATA_W-1:0] d,
                        input logic [SEL_W-1:0] s);
   wb_stb_i = 1'b1;
   wb_we_i  = 1'b1;
   wb_adr_i = {a, 2'b00};
   wb_dat_i = d;
   wb_sel_i = s;
   wait_ack();
   shadow[a] = merge_bytes(shadow[a], d, s);
endtask

// one read inside an open cycle, data is checked by the compare process
task automatic get_word(input logic [WORD_AW-1:0] a);
   wb_stb_i = 1'b1;
   wb_we_i  = 1'b0;
   wb_adr_i = {a, 2'b00};
   wb_sel_i = '1;
   wait_ack();
   n_reads++;
endtask

task automatic write_single(input logic [WORD_AW-1:0] a, input logic [DATA_W-1:0] d,
                            input logic [SEL_W-1:0] s);
   start_cycle();
   put_word(a, d, s);
   end_cycle();
endtask

// sequential block read, addresses wrap at the top
task automatic read_block(input logic [WORD_AW-1:0] start, input int len);
   logic [WORD_AW-1:0] a;
   start_cycle();
   for (int i = 0; i < len; i++) begin
      a = start + WORD_AW'(i);
      get_word(a);
   end
   end_cycle();
endtask

`endif

/* sim/tb_mem_bridge.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_mem_bridge import mem_bridge_pkg::*; ();

   localparam int MODE_FILL      = 0;     // address pattern, all lanes
   localparam int MODE_RAND      = 1;     // random data, all lanes
   localparam int MODE_RSEL      = 2;     // random data and lanes
   localparam int PRELOAD_BLOCKS = MEM_WORDS / WRITE_BURST_MAX;
   localparam int N_DIRECTED     = 18;
   localparam int N_RAND         = 200;
   localparam int N_XFERS        = PRELOAD_BLOCKS + N_DIRECTED + N_RAND;
   localparam int WDOG_CYCLES    = N_XFERS * 200;

   logic               wb_clk = 1'b0;
   logic               mem_rst;
   logic               wb_cyc_i;
   logic               wb_stb_i;
   logic               wb_we_i;
   logic [SEL_W-1:0]   wb_sel_i;
   logic [ADDR_W-1:0]  wb_adr_i;
   logic [DATA_W-1:0]  wb_dat_i;
   logic               wb_ack_o;
   logic [DATA_W-1:0]  wb_dat_o;

   logic [DATA_W-1:0]  shadow [MEM_WORDS];   // expected memory contents
   integer             seed = 36;
   int                 n_reads = 0;          // read acks taken by the master
   int                 n_checked = 0;        // read acks compared

   always #20 wb_clk = ~wb_clk;              // 40 ns period

   mem_bridge_top u_dut (
      .wb_clk   (wb_clk),
      .mem_rst  (mem_rst),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_sel_i (wb_sel_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_ack_o (wb_ack_o),
      .wb_dat_o (wb_dat_o)
   );

   ////////////////////
   // reference model
   ////////////////////

   // a write changes only the lanes with a select bit
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [SEL_W-1:0] sel);
      logic [DATA_W-1:0] r;
      r = old_w;
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b]) r[8*b +: 8] = new_w[8*b +: 8];
      end
      return r;
   endfunction

   function automatic logic [DATA_W-1:0] expected_word(input logic [WORD_AW-1:0] a);
      return shadow[a];                      // all earlier writes merged in
   endfunction

   // odd multiplier, every address bit reaches the word
   function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_AW-1:0] a);
      return (DATA_W'(a) * DATA_W'(32'h9e37_79b1)) ^ DATA_W'(32'h5a5a_a5a5);
   endfunction

   `include "tb_checks.svh"

   task automatic write_block(input logic [WORD_AW-1:0] start, input int len, input int mode);
      logic [WORD_AW-1:0] a;
      logic [DATA_W-1:0]  d;
      logic [SEL_W-1:0]   s;
      start_cycle();
      for (int i = 0; i < len; i++) begin
         a = start + WORD_AW'(i);           // wraps like the memory
         d = (mode == MODE_FILL) ? fill_word(a) : DATA_W'($random(seed));
         s = (mode == MODE_RSEL) ? SEL_W'($random(seed)) : '1;
         put_word(a, d, s);
      end
      end_cycle();
   endtask

   ////////////////////
   // compare and watchdog
   ////////////////////

   // ack is registered, so 1 ns after the edge it is settled
   always @(posedge wb_clk) begin
      #1;
      if (!wb_cyc_i) begin
         check_ack_idle(wb_ack_o);
      end else if (wb_stb_i && !wb_we_i && wb_ack_o) begin
         check_data(wb_dat_o, expected_word(wb_adr_i[ADDR_W-1:2]), wb_adr_i);
         n_checked++;
      end
   end

   initial begin
      repeat (WDOG_CYCLES) @(posedge wb_clk);
      $display("watchdog expired after %0d cycles, the bus stopped answering", WDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation timeout");
   end

   ////////////////////
   // stimulus
   ////////////////////

   initial begin
      logic [31:0]        op;
      logic [WORD_AW-1:0] blk_start;
      int                 len;
      mem_rst  = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_sel_i = '0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      repeat (5) @(posedge wb_clk);
      #2 mem_rst = 1'b0;
      repeat (4) @(posedge wb_clk);        // idle, compare process watches ack
      // every word gets a known value first
      for (int b = 0; b < PRELOAD_BLOCKS; b++) begin
         write_block(WORD_AW'(b * WRITE_BURST_MAX), WRITE_BURST_MAX, MODE_FILL);
      end
      // single writes read back
      write_block(10'h040, 1, MODE_RAND);
      write_block(10'h123, 1, MODE_RAND);
      write_block(10'h3ff, 1, MODE_RAND);
      read_block(10'h040, 1);
      read_block(10'h123, 1);
      read_block(10'h3ff, 1);
      // partial byte lanes
      write_single(10'h080, 32'h1122_3344, 4'b0001);
      write_single(10'h080, 32'haabb_ccdd, 4'b1100);
      write_single(10'h081, 32'h5566_7788, 4'b0110);
      read_block(10'h080, 2);
      read_block(10'h100, 20);               // crosses two refills
      // writes into the prefetched range
      read_block(10'h200, 4);
      write_single(10'h204, 32'hcafe_f00d, 4'hf);
      read_block(10'h204, 1);
      write_single(10'h205, 32'h0bad_beef, 4'b0101);
      read_block(10'h205, 3);
      read_block(10'h210, 3);                // jump away
      read_block(10'h2f0, 2);
      // random mix
      for (int r = 0; r < N_RAND; r++) begin
         op        = $random(seed);
         blk_start = WORD_AW'($random(seed));
         len       = 1 + ({$random(seed)} % 20);
         if (op[0]) write_block(blk_start, len, MODE_RSEL);
         else       read_block(blk_start, len);
      end
      repeat (4) @(posedge wb_clk);
      if (n_checked == n_reads && n_reads > 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("read acks compared %0d, reads done %0d", n_checked, n_reads);
         $display("TEST RESULT: FAIL");
         $fatal(1, "not every read ack was compared");
      end
   end

endmodule

`default_nettype wire

/* rtl/mem_bridge_top.sv */
`default_nettype none
`timescale 1ns/1ns

module mem_bridge_top import mem_bridge_pkg::*; (
   input  logic              wb_clk,
   input  logic              mem_rst,
   // wishbone classic slave
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   input  logic              wb_we_i,
   input  logic [SEL_W-1:0]  wb_sel_i,
   input  logic [ADDR_W-1:0] wb_adr_i,
   input  logic [DATA_W-1:0] wb_dat_i,
   output logic              wb_ack_o,
   output logic [DATA_W-1:0] wb_dat_o
);

   ////////////////////
   // internal buses
   ////////////////////

   // command port, decode to exec
   logic               cmd_valid;
   logic               cmd_write;
   logic [WORD_AW-1:0] cmd_addr;
   logic [LEN_W-1:0]   cmd_len;
   logic               cmd_ready;
   // write data port
   logic               wr_push;
   logic [DATA_W-1:0]  wr_data;
   logic [SEL_W-1:0]   wr_sel;
   logic               wr_full;
   // read data port, exec to buffer
   logic               rd_valid;
   logic [DATA_W-1:0]  rd_data;
   // lookup, decode and buffer
   logic               rd_req;
   logic [WORD_AW-1:0] rd_addr;
   logic               inval;
   logic               rd_ack;
   logic               fetch;
   logic [WORD_AW-1:0] fetch_addr;

   // decode stage
   wb_cycle_decode u_decode (
      .wb_clk       (wb_clk),
      .mem_rst      (mem_rst),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_sel_i     (wb_sel_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_ack_o     (wb_ack_o),
      .rd_req_o     (rd_req),
      .rd_addr_o    (rd_addr),
      .inval_o      (inval),
      .rd_ack_i     (rd_ack),
      .fetch_i      (fetch),
      .fetch_addr_i (fetch_addr),
      .cmd_valid_o  (cmd_valid),
      .cmd_write_o  (cmd_write),
      .cmd_addr_o   (cmd_addr),
      .cmd_len_o    (cmd_len),
      .cmd_ready_i  (cmd_ready),
      .wr_push_o    (wr_push),
      .wr_data_o    (wr_data),
      .wr_sel_o     (wr_sel),
      .wr_full_i    (wr_full)
   );

   // execute stage with the memory
   sdram_burst_exec u_exec (
      .wb_clk      (wb_clk),
      .mem_rst     (mem_rst),
      .cmd_valid_i (cmd_valid),
      .cmd_write_i (cmd_write),
      .cmd_addr_i  (cmd_addr),
      .cmd_len_i   (cmd_len),
      .cmd_ready_o (cmd_ready),
      .wr_push_i   (wr_push),
      .wr_data_i   (wr_data),
      .wr_sel_i    (wr_sel),
      .wr_full_o   (wr_full),
      .rd_valid_o  (rd_valid),
      .rd_data_o   (rd_data)
   );

   // result stage, read-ahead
   readahead_buffer u_result (
      .wb_clk       (wb_clk),
      .mem_rst      (mem_rst),
      .rd_req_i     (rd_req),
      .rd_addr_i    (rd_addr),
      .inval_i      (inval),
      .rd_ack_o     (rd_ack),
      .wb_dat_o     (wb_dat_o),
      .fetch_o      (fetch),
      .fetch_addr_o (fetch_addr),
      .rd_valid_i   (rd_valid),
      .rd_data_i    (rd_data)
   );

endmodule

`default_nettype wire

/* rtl/readahead_buffer.sv */
`default_nettype none
`timescale 1ns/1ns

module readahead_buffer import mem_bridge_pkg::*; (
   input  logic               wb_clk,
   input  logic               mem_rst,
   // lookup from decode
   input  logic               rd_req_i,
   input  logic [WORD_AW-1:0] rd_addr_i,
   input  logic               inval_i,
   output logic               rd_ack_o,
   output logic [DATA_W-1:0]  wb_dat_o,
   output logic               fetch_o,
   output logic [WORD_AW-1:0] fetch_addr_o,
   // read data from exec
   input  logic               rd_valid_i,
   input  logic [DATA_W-1:0]  rd_data_i
);

   logic [DATA_W-1:0]   rb_mem [READ_BURST_LEN];   // prefetched words
   logic [RB_PTR_W-1:0] wptr;
   logic [RB_PTR_W-1:0] rptr;
   logic [LEN_W-1:0]    held;       // valid words sitting in the fifo
   logic [LEN_W-1:0]    rd_left;    // valid words still to arrive
   logic [LEN_W-1:0]    inv_cnt;    // stale words still to arrive, dropped
   logic [WORD_AW-1:0]  adr_next;   // address of the next word in sequence

   logic                match;
   logic                hit;
   logic                miss;
   logic                drop_all;
   logic                stale;
   logic                push;

   ////////////////////
   // hit or miss
   ////////////////////

   assign match = rd_addr_i == adr_next;
   // served as soon as the word is in the fifo
   assign hit   = rd_req_i & match & (held != '0);
   // other address, or nothing left in this sequence
   assign miss  = rd_req_i & (~match | ((held == '0) & (rd_left == '0)));
   // matching request with words in flight just waits

   assign drop_all = miss | inval_i;                  // never together with a hit
   assign stale    = rd_valid_i & (inv_cnt != '0);    // old burst tail
   assign push     = rd_valid_i & (inv_cnt == '0) & ~drop_all;

   ////////////////////
   // control
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         rd_ack_o <= 1'b0;
         fetch_o  <= 1'b0;
         wptr     <= '0;
         rptr     <= '0;
         held     <= '0;
         rd_left  <= '0;
         inv_cnt  <= '0;
         adr_next <= '0;
      end else begin
         rd_ack_o <= hit;             // ack in the cycle after the strobe
         fetch_o  <= miss;            // decode turns this into a read command
         if (drop_all) begin
            rptr <= wptr;             // held words gone at once
            held <= '0;
            // whatever is in flight becomes stale, the word arriving now included
            inv_cnt <= inv_cnt + rd_left - LEN_W'(rd_valid_i);
            rd_left <= miss ? LEN_W'(READ_BURST_LEN) : '0;
            if (miss) adr_next <= rd_addr_i;   // new burst starts here
         end else begin
            if (stale) inv_cnt <= inv_cnt - LEN_W'(1);
            if (push) begin
               wptr    <= wptr + RB_PTR_W'(1);
               rd_left <= rd_left - LEN_W'(1);
            end
            if (hit) begin
               rptr     <= rptr + RB_PTR_W'(1);
               adr_next <= adr_next + WORD_AW'(1);   // sequential read expected
            end
            held <= held + LEN_W'(push) - LEN_W'(hit);
         end
      end
   end

   ////////////////////
   // data path
   ////////////////////

   // held + rd_left never exceeds the depth, push and pop slots differ
   always_ff @(posedge wb_clk) begin
      if (push) rb_mem[wptr] <= rd_data_i;
      if (hit)  wb_dat_o     <= rb_mem[rptr];
      if (miss) fetch_addr_o <= rd_addr_i;
   end

endmodule

`default_nettype wire

/* rtl/sdram_burst_exec.sv */
`default_nettype none
`timescale 1ns/1ns

module sdram_burst_exec import mem_bridge_pkg::*; (
   input  logic               wb_clk,
   input  logic               mem_rst,
   // command port
   input  logic               cmd_valid_i,
   input  logic               cmd_write_i,
   input  logic [WORD_AW-1:0] cmd_addr_i,
   input  logic [LEN_W-1:0]   cmd_len_i,
   output logic               cmd_ready_o,
   // write data port
   input  logic               wr_push_i,
   input  logic [DATA_W-1:0]  wr_data_i,
   input  logic [SEL_W-1:0]   wr_sel_i,
   output logic               wr_full_o,
   // read data port, no back-pressure
   output logic               rd_valid_o,
   output logic [DATA_W-1:0]  rd_data_o
);

   // memory array, stands in for the sdram
   logic [DATA_W-1:0]   mem [MEM_WORDS];

   // write staging fifo
   logic [DATA_W-1:0]   stg_data [WRITE_BURST_MAX];
   logic [SEL_W-1:0]    stg_sel  [WRITE_BURST_MAX];
   logic [WB_PTR_W-1:0] stg_wp;
   logic [WB_PTR_W-1:0] stg_rp;
   logic [LEN_W-1:0]    stg_cnt;      // staged words, 0..16

   // burst slot
   logic                busy;
   logic                bst_write;
   logic [WORD_AW-1:0]  bst_addr;     // current word address, wraps at top
   logic [LEN_W-1:0]    bst_left;     // words left after this one

   logic                cmd_take;
   logic                wr_step;      // one word written this cycle
   logic                rd_step;      // one word read this cycle

   assign cmd_ready_o = ~busy;                   // one burst at a time
   assign cmd_take    = cmd_valid_i & cmd_ready_o;
   assign wr_step     = busy & bst_write;
   assign rd_step     = busy & ~bst_write;
   assign wr_full_o   = stg_cnt == LEN_W'(WRITE_BURST_MAX);

   ////////////////////
   // write staging
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         stg_wp  <= '0;
         stg_rp  <= '0;
         stg_cnt <= '0;
      end else begin
         if (wr_push_i) stg_wp <= stg_wp + WB_PTR_W'(1);
         if (wr_step)   stg_rp <= stg_rp + WB_PTR_W'(1);   // write burst pops
         stg_cnt <= stg_cnt + LEN_W'(wr_push_i) - LEN_W'(wr_step);
      end
   end

   // staged words, data with byte selects
   always_ff @(posedge wb_clk) begin
      if (wr_push_i) begin
         stg_data[stg_wp] <= wr_data_i;
         stg_sel[stg_wp]  <= wr_sel_i;
      end
   end

   ////////////////////
   // burst sequencing
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         busy       <= 1'b0;
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_step;                   // read port is registered
         if (cmd_take) begin
            busy <= 1'b1;
         end else if (busy && bst_left == '0) begin
            busy <= 1'b0;                         // last word done this cycle
         end
      end
   end

   // N words in N cycles after acceptance
   always_ff @(posedge wb_clk) begin
      if (cmd_take) begin
         bst_write <= cmd_write_i == CMD_WRITE;
         bst_addr  <= cmd_addr_i;
         bst_left  <= cmd_len_i;
      end else if (busy) begin
         bst_addr <= bst_addr + WORD_AW'(1);      // natural wrap of the array
         bst_left <= bst_left - LEN_W'(1);
      end
   end

   ////////////////////
   // memory array
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (wr_step) begin
         for (int b = 0; b < SEL_W; b++) begin
            // only selected lanes change
            if (stg_sel[stg_rp][b]) mem[bst_addr][8*b +: 8] <= stg_data[stg_rp][8*b +: 8];
         end
      end
      if (rd_step) rd_data_o <= mem[bst_addr];     // first word two cycles after accept
   end

endmodule

`default_nettype wire

/* rtl/wb_cycle_decode.sv */
`default_nettype none
`timescale 1ns/1ns

module wb_cycle_decode import mem_bridge_pkg::*; (
   input  logic               wb_clk,
   input  logic               mem_rst,
   // wishbone classic slave
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  logic [SEL_W-1:0]   wb_sel_i,
   input  logic [ADDR_W-1:0]  wb_adr_i,
   input  logic [DATA_W-1:0]  wb_dat_i,
   output logic               wb_ack_o,
   // lookup in read-ahead buffer
   output logic               rd_req_o,
   output logic [WORD_AW-1:0] rd_addr_o,
   output logic               inval_o,
   input  logic               rd_ack_i,
   input  logic               fetch_i,
   input  logic [WORD_AW-1:0] fetch_addr_i,
   // command port
   output logic               cmd_valid_o,
   output logic               cmd_write_o,
   output logic [WORD_AW-1:0] cmd_addr_o,
   output logic [LEN_W-1:0]   cmd_len_o,
   input  logic               cmd_ready_i,
   // write data port
   output logic               wr_push_o,
   output logic [DATA_W-1:0]  wr_data_o,
   output logic [SEL_W-1:0]   wr_sel_o,
   input  logic               wr_full_i
);

   logic [1:0]         state;
   logic [LEN_W-1:0]   wcnt;         // words gathered in current burst
   logic [WORD_AW-1:0] wr_base;      // burst start word address
   logic [WORD_AW-1:0] wr_next;      // address expected for a sequential write
   logic [WORD_AW-1:0] adr_word;
   logic               wr_ack;       // write ack, one cycle after strobe
   logic               wr_stb;
   logic               rd_stb;
   logic               seq_ok;
   logic               burst_full;
   logic               wr_take;      // write strobe accepted this cycle
   logic               flush_go;     // close the gathered burst

   ////////////////////
   // strobe sorting
   ////////////////////

   assign adr_word   = wb_adr_i[ADDR_W-1:2];   // byte lanes go in wb_sel_i
   // the ack cycle never counts as a new strobe
   assign wr_stb     = wb_cyc_i & wb_stb_i & wb_we_i & ~wb_ack_o;
   assign rd_stb     = wb_cyc_i & wb_stb_i & ~wb_we_i & ~wb_ack_o;
   assign wr_next    = wr_base + WORD_AW'(wcnt);
   assign seq_ok     = adr_word == wr_next;
   assign burst_full = wcnt == LEN_W'(WRITE_BURST_MAX);

   assign wr_take = wr_stb & ~wr_full_i &
                    ((state == ST_IDLE) | (state == ST_READ) |
                     ((state == ST_WRITE) & seq_ok & ~burst_full));

   // end of cycle, full burst, or anything that does not extend the burst
   assign flush_go = (state == ST_WRITE) &
                     (~wb_cyc_i | burst_full | rd_stb | (wr_stb & ~seq_ok));

   assign rd_req_o  = rd_stb & ((state == ST_IDLE) | (state == ST_READ));
   assign rd_addr_o = adr_word;
   assign wb_ack_o  = wr_ack | rd_ack_i;         // only one side acks at a time

   ////////////////////
   // main fsm
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         state     <= ST_IDLE;
         wcnt      <= '0;
         wr_ack    <= 1'b0;
         wr_push_o <= 1'b0;
         inval_o   <= 1'b0;
      end else begin
         wr_ack    <= wr_take;
         wr_push_o <= wr_take;                    // word goes to staging with the ack
         inval_o   <= wr_take & (state != ST_WRITE);   // first write of a burst
         case (state)
            ST_IDLE, ST_READ: begin
               if (wr_take) begin
                  state <= ST_WRITE;
                  wcnt  <= LEN_W'(1);
               end else if (rd_stb) begin
                  state <= ST_READ;
               end else if (~wb_cyc_i) begin
                  state <= ST_IDLE;
               end
            end
            ST_WRITE: begin
               if (flush_go) begin
                  state <= ST_FLUSH;
               end else if (wr_take) begin
                  wcnt <= wcnt + LEN_W'(1);
               end
            end
            ST_FLUSH: begin
               if (cmd_valid_o & cmd_ready_i) state <= ST_IDLE;   // exec took it
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // payload, no reset
   always_ff @(posedge wb_clk) begin
      if (wr_take & (state != ST_WRITE)) wr_base <= adr_word;
      wr_data_o <= wb_dat_i;
      wr_sel_o  <= wb_sel_i;
   end

   ////////////////////
   // command issue
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         cmd_valid_o <= 1'b0;
      end else if (flush_go | fetch_i) begin
         cmd_valid_o <= 1'b1;
      end else if (cmd_ready_i) begin
         cmd_valid_o <= 1'b0;                     // held until accepted
      end
   end

   always_ff @(posedge wb_clk) begin
      if (flush_go) begin
         cmd_write_o <= CMD_WRITE;
         cmd_addr_o  <= wr_base;
         cmd_len_o   <= wcnt - LEN_W'(1);         // length field is words minus one
      end else if (fetch_i) begin
         cmd_write_o <= CMD_READ;
         cmd_addr_o  <= fetch_addr_i;
         cmd_len_o   <= LEN_W'(READ_BURST_LEN - 1);
      end
   end

endmodule

`default_nettype wire

/* rtl/mem_bridge_pkg.sv */
`default_nettype none

package mem_bridge_pkg;

   ////////////////////
   // bus and memory sizes
   ////////////////////

   localparam int DATA_W    = 32;             // wishbone and memory word
   localparam int SEL_W     = DATA_W / 8;     // one select per byte
   localparam int ADDR_W    = 12;             // byte address, 4 KB space
   localparam int WORD_AW   = ADDR_W - 2;     // word address
   localparam int MEM_WORDS = 1 << WORD_AW;   // 1024 words

   ////////////////////
   // burst geometry
   ////////////////////

   // read bursts are always full length
   localparam int READ_BURST_LEN  = 8;
   // write bursts flush at this depth at the latest
   localparam int WRITE_BURST_MAX = 16;
   localparam int LEN_W           = 5;        // holds 0..16, counters and burst length

   localparam int RB_PTR_W = $clog2(READ_BURST_LEN);    // read-ahead fifo pointer
   localparam int WB_PTR_W = $clog2(WRITE_BURST_MAX);   // write staging pointer

   ////////////////////
   // command codes
   ////////////////////

   // write / read with autoprecharge on the real controller
   localparam logic CMD_WRITE = 1'b1;
   localparam logic CMD_READ  = 1'b0;

   ////////////////////
   // decode fsm states
   ////////////////////

   localparam logic [1:0] ST_IDLE  = 2'd0;    // no transfer under way
   localparam logic [1:0] ST_WRITE = 2'd1;    // gathering write words
   localparam logic [1:0] ST_FLUSH = 2'd2;    // write command waiting for exec
   localparam logic [1:0] ST_READ  = 2'd3;    // read cycle, buffer serves data

endpackage

`default_nettype wire
